/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_rv_core
FLIST     ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LOG       ?= sim.log
FAIL_MSG  ?= Simulation finished: FAIL

SRCS := $(wildcard *.sv)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Run failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* compile.f */
rv_pkg.sv
stage_reg.sv
fetch_stage.sv
reg_file.sv
decode_stage.sv
execute_stage.sv
mem_wb_stage.sv
rv_core.sv
tb_clk_gen.sv
rv_core_asserts.sv
tb_rv_core.sv

/* decode_stage.sv */
// Decode stage: control decode, immediates, register read, load-use check and the ID/EX register
`timescale 1ns/1ps

module decode_stage import rv_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  logic      dm_ready,
	input  logic      redirect,
	input  if_id_t    if_id,
	bypass_if.snk     byp,
	output logic      load_stall,
	output id_ex_t    id_ex
);

	logic [6:0]            opcode;
	logic [2:0]            funct3;
	logic [6:0]            funct7;
	logic [reg_addr_w-1:0] rs1_idx;
	logic [reg_addr_w-1:0] rs2_idx;
	logic [reg_addr_w-1:0] rd_idx;
	logic [xlen-1:0]       rd1;
	logic [xlen-1:0]       rd2;
	logic [xlen-1:0]       imm_i;
	logic [xlen-1:0]       imm_s;
	logic [xlen-1:0]       imm_b;
	logic [xlen-1:0]       imm_j;
	logic [xlen-1:0]       imm;
	logic                  use_rs1;
	logic                  use_rs2;
	ctrl_t                 ctrl;
	id_ex_t                idex_d;

	assign opcode  = if_id.instr[6:0];
	assign funct3  = if_id.instr[14:12];
	assign funct7  = if_id.instr[31:25];
	assign rs1_idx = if_id.instr[19:15];
	assign rs2_idx = if_id.instr[24:20];
	assign rd_idx  = if_id.instr[11:7];

	assign imm_i = {{20{if_id.instr[31]}}, if_id.instr[31:20]};
	assign imm_s = {{20{if_id.instr[31]}}, if_id.instr[31:25], if_id.instr[11:7]};
	assign imm_b = {{19{if_id.instr[31]}}, if_id.instr[31], if_id.instr[7],
		if_id.instr[30:25], if_id.instr[11:8], 1'b0};
	assign imm_j = {{11{if_id.instr[31]}}, if_id.instr[31], if_id.instr[19:12],
		if_id.instr[20], if_id.instr[30:21], 1'b0};

	//////////////////////////////////////////////////////////////////////
	// Control decode, anything unsupported becomes a no-op
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		ctrl    = '0;
		imm     = imm_i;
		use_rs1 = 1'b1;
		use_rs2 = 1'b0;
		case (opcode)
			OP: begin
				use_rs2        = 1'b1;
				ctrl.reg_write = 1'b1;
				case (funct3)
					F3_ADD:  ctrl.alu_op = (funct7 == F7_SUB) ? alu_sub : alu_add;
					F3_SLT:  ctrl.alu_op = alu_slt;
					F3_XOR:  ctrl.alu_op = alu_xor;
					F3_OR:   ctrl.alu_op = alu_or;
					F3_AND:  ctrl.alu_op = alu_and;
					default: ctrl.reg_write = 1'b0;
				endcase
			end
			OP_IMM: begin
				ctrl.reg_write   = (funct3 == F3_ADD);
				ctrl.alu_src_imm = 1'b1;
			end
			LOAD: begin
				ctrl.reg_write   = (funct3 == F3_WORD);
				ctrl.mem_read    = (funct3 == F3_WORD);
				ctrl.alu_src_imm = 1'b1;
			end
			STORE: begin
				use_rs2          = 1'b1;
				imm              = imm_s;
				ctrl.mem_write   = (funct3 == F3_WORD);
				ctrl.alu_src_imm = 1'b1;
			end
			BRANCH: begin
				use_rs2        = 1'b1;
				imm            = imm_b;
				ctrl.branch    = (funct3 == F3_BEQ) || (funct3 == F3_BNE);
				ctrl.branch_ne = (funct3 == F3_BNE);
			end
			JAL: begin
				use_rs1        = 1'b0;
				imm            = imm_j;
				ctrl.reg_write = 1'b1;
				ctrl.jump      = 1'b1;
			end
			default: begin
				use_rs1 = 1'b0;
			end
		endcase
	end

	// Written back from MEM/WB
	reg_file u_reg_file (
		.clk     (clk),
		.rst     (rst),
		.rs1     (rs1_idx),
		.rs2     (rs2_idx),
		.wr_en   (byp.wb_reg_write),
		.wr_addr (byp.wb_rd),
		.wr_data (byp.wb_data),
		.rd1     (rd1),
		.rd2     (rd2)
	);

	// Load in execute whose rd this instruction needs
	assign load_stall = id_ex.ctrl.mem_read && (id_ex.rd != '0) &&
		((use_rs1 && id_ex.rd == rs1_idx) || (use_rs2 && id_ex.rd == rs2_idx));

	assign idex_d = '{ctrl: ctrl, pc: if_id.pc, rs1: rs1_idx, rs2: rs2_idx,
		rs1_val: rd1, rs2_val: rd2, imm: imm, rd: rd_idx};

	stage_reg #(.payload_t(id_ex_t)) u_id_ex (
		.clk   (clk),
		.rst   (rst),
		.hold  (!dm_ready),
		.flush (redirect || load_stall),
		.d     (idex_d),
		.q     (id_ex)
	);

endmodule

/* execute_stage.sv */
// Execute stage: operand forwarding, ALU, branch and jump resolution, and the EX/MEM register
`timescale 1ns/1ps

module execute_stage import rv_pkg::*; (
	input  logic            clk,
	input  logic            rst,
	input  logic            dm_ready,
	input  id_ex_t          id_ex,
	bypass_if.snk           byp,
	output logic            redirect,
	output logic [xlen-1:0] redirect_pc,
	output ex_mem_t         ex_mem
);

	logic [xlen-1:0] fwd_a;
	logic [xlen-1:0] fwd_b;
	logic [xlen-1:0] alu_b;
	logic [xlen-1:0] alu_out;
	logic [xlen-1:0] link_pc;
	logic            operands_eq;
	ex_mem_t         exmem_d;

	// Youngest producer wins, x0 is never forwarded
	function automatic logic [xlen-1:0] forward(
		input logic [reg_addr_w-1:0] idx,
		input logic [xlen-1:0]       reg_val
	);
		if (byp.exm_reg_write && byp.exm_rd != '0 && byp.exm_rd == idx) begin
			return byp.exm_result;
		end else if (byp.wb_reg_write && byp.wb_rd != '0 && byp.wb_rd == idx) begin
			return byp.wb_data;
		end
		return reg_val;
	endfunction

	assign fwd_a = forward(id_ex.rs1, id_ex.rs1_val);
	assign fwd_b = forward(id_ex.rs2, id_ex.rs2_val);
	assign alu_b = id_ex.ctrl.alu_src_imm ? id_ex.imm : fwd_b;

	//////////////////////////////////////////////////////////////////////
	// ALU
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		case (id_ex.ctrl.alu_op)
			alu_sub: alu_out = fwd_a - alu_b;
			alu_and: alu_out = fwd_a & alu_b;
			alu_or:  alu_out = fwd_a | alu_b;
			alu_xor: alu_out = fwd_a ^ alu_b;
			alu_slt: alu_out = {{(xlen-1){1'b0}}, $signed(fwd_a) < $signed(alu_b)};
			default: alu_out = fwd_a + alu_b;
		endcase
	end

	// Branch and jal targets share the pc-relative adder
	assign link_pc     = id_ex.pc + xlen'(4);
	assign redirect_pc = id_ex.pc + id_ex.imm;
	assign operands_eq = (fwd_a == fwd_b);
	assign redirect    = id_ex.ctrl.jump ||
		(id_ex.ctrl.branch && (id_ex.ctrl.branch_ne ? !operands_eq : operands_eq));

	assign exmem_d = '{
		reg_write:  id_ex.ctrl.reg_write,
		mem_read:   id_ex.ctrl.mem_read,
		mem_write:  id_ex.ctrl.mem_write,
		result:     id_ex.ctrl.jump ? link_pc : alu_out,
		store_data: fwd_b,
		rd:         id_ex.rd
	};

	stage_reg #(.payload_t(ex_mem_t)) u_ex_mem (
		.clk   (clk),
		.rst   (rst),
		.hold  (!dm_ready),
		.flush (1'b0),
		.d     (exmem_d),
		.q     (ex_mem)
	);

endmodule

/* fetch_stage.sv */
// Fetch stage holding the PC and the IF/ID register; drives the instruction memory address
`timescale 1ns/1ps

module fetch_stage import rv_pkg::*; (
	input  logic            clk,
	input  logic            rst,
	input  logic            dm_ready,
	input  logic            redirect,
	input  logic [xlen-1:0] redirect_pc,
	input  logic            load_stall,
	input  logic [xlen-1:0] im_data,
	output logic [xlen-1:0] im_addr,
	output if_id_t          if_id
);

	logic [xlen-1:0] pc;
	logic [xlen-1:0] pc_plus4;
	logic            ifid_hold;
	if_id_t          ifid_d;

	assign pc_plus4 = pc + xlen'(4);
	assign im_addr  = pc;

	// Not ready, then redirect, then load stall, then sequential
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			pc <= reset_pc;
		end else if (dm_ready) begin
			if (redirect) begin
				pc <= redirect_pc;
			end else if (!load_stall) begin
				pc <= pc_plus4;
			end
		end
	end

	// Redirect squashes the word being fetched
	assign ifid_hold = !dm_ready || (load_stall && !redirect);
	assign ifid_d    = '{pc: pc, instr: im_data};

	stage_reg #(.payload_t(if_id_t)) u_if_id (
		.clk   (clk),
		.rst   (rst),
		.hold  (ifid_hold),
		.flush (redirect),
		.d     (ifid_d),
		.q     (if_id)
	);

endmodule

/* mem_wb_stage.sv */
// Memory and writeback stage: data memory port, MEM/WB register and the forwarding sources
`timescale 1ns/1ps

module mem_wb_stage import rv_pkg::*; (
	input  logic            clk,
	input  logic            rst,
	input  logic            dm_ready,
	input  ex_mem_t         ex_mem,
	output logic            dm_cs,
	output logic            dm_we,
	output logic [xlen-1:0] dm_addr,
	output logic [xlen-1:0] dm_wdata,
	input  logic [xlen-1:0] dm_rdata,
	bypass_if.src           byp
);

	mem_wb_t memwb_d;
	mem_wb_t mem_wb;

	// Word access straight from EX/MEM
	assign dm_cs    = ex_mem.mem_read || ex_mem.mem_write;
	assign dm_we    = ex_mem.mem_write;
	assign dm_addr  = ex_mem.result;
	assign dm_wdata = ex_mem.store_data;

	assign memwb_d = '{
		reg_write: ex_mem.reg_write,
		rd:        ex_mem.rd,
		wb_data:   ex_mem.mem_read ? dm_rdata : ex_mem.result
	};

	stage_reg #(.payload_t(mem_wb_t)) u_mem_wb (
		.clk   (clk),
		.rst   (rst),
		.hold  (!dm_ready),
		.flush (1'b0),
		.d     (memwb_d),
		.q     (mem_wb)
	);

	// A load holds an address here, not its data
	assign byp.exm_reg_write = ex_mem.reg_write && !ex_mem.mem_read;
	assign byp.exm_rd        = ex_mem.rd;
	assign byp.exm_result    = ex_mem.result;
	assign byp.wb_reg_write  = mem_wb.reg_write;
	assign byp.wb_rd         = mem_wb.rd;
	assign byp.wb_data       = mem_wb.wb_data;

endmodule

/* reg_file.sv */
// Integer register file, two read ports and one write port with write-first read bypass
`timescale 1ns/1ps

module reg_file import rv_pkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	input  logic [reg_addr_w-1:0] rs1,
	input  logic [reg_addr_w-1:0] rs2,
	input  logic                  wr_en,
	input  logic [reg_addr_w-1:0] wr_addr,
	input  logic [xlen-1:0]       wr_data,
	output logic [xlen-1:0]       rd1,
	output logic [xlen-1:0]       rd2
);

	logic [xlen-1:0] regs [2**reg_addr_w];

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int i = 0; i < 2**reg_addr_w; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && wr_addr != '0) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// x0 reads zero, same-cycle write returns the new value
	assign rd1 = (rs1 == '0) ? '0 : (wr_en && wr_addr == rs1) ? wr_data : regs[rs1];
	assign rd2 = (rs2 == '0) ? '0 : (wr_en && wr_addr == rs2) ? wr_data : regs[rs2];

endmodule

/* rv_core.sv */
// Five-stage RV32I subset core top level with the forwarding interface; instantiated by the testbench
`timescale 1ns/1ps

// Results of the EX/MEM and MEM/WB registers, for forwarding and register write
interface bypass_if import rv_pkg::*; ();
	logic                  exm_reg_write;
	logic [reg_addr_w-1:0] exm_rd;
	logic [xlen-1:0]       exm_result;
	logic                  wb_reg_write;
	logic [reg_addr_w-1:0] wb_rd;
	logic [xlen-1:0]       wb_data;

	modport src (
		output exm_reg_write, exm_rd, exm_result,
		output wb_reg_write, wb_rd, wb_data
	);
	modport snk (
		input exm_reg_write, exm_rd, exm_result,
		input wb_reg_write, wb_rd, wb_data
	);
endinterface

module rv_core import rv_pkg::*; (
	input  logic            clk,
	input  logic            rst,
	output logic [xlen-1:0] im_addr,
	input  logic [xlen-1:0] im_data,
	output logic            dm_cs,
	output logic            dm_we,
	output logic [xlen-1:0] dm_addr,
	output logic [xlen-1:0] dm_wdata,
	input  logic [xlen-1:0] dm_rdata,
	input  logic            dm_ready
);

	if_id_t          if_id;
	id_ex_t          id_ex;
	ex_mem_t         ex_mem;
	logic            redirect;
	logic [xlen-1:0] redirect_pc;
	logic            load_stall;

	bypass_if byp ();

	//////////////////////////////////////////////////////////////////////
	// Input side
	//////////////////////////////////////////////////////////////////////
	fetch_stage u_fetch (
		.clk         (clk),
		.rst         (rst),
		.dm_ready    (dm_ready),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.load_stall  (load_stall),
		.im_data     (im_data),
		.im_addr     (im_addr),
		.if_id       (if_id)
	);

	//////////////////////////////////////////////////////////////////////
	// Processing
	//////////////////////////////////////////////////////////////////////
	decode_stage u_decode (
		.clk        (clk),
		.rst        (rst),
		.dm_ready   (dm_ready),
		.redirect   (redirect),
		.if_id      (if_id),
		.byp        (byp.snk),
		.load_stall (load_stall),
		.id_ex      (id_ex)
	);

	execute_stage u_execute (
		.clk         (clk),
		.rst         (rst),
		.dm_ready    (dm_ready),
		.id_ex       (id_ex),
		.byp         (byp.snk),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.ex_mem      (ex_mem)
	);

	//////////////////////////////////////////////////////////////////////
	// Output side
	//////////////////////////////////////////////////////////////////////
	mem_wb_stage u_mem_wb (
		.clk      (clk),
		.rst      (rst),
		.dm_ready (dm_ready),
		.ex_mem   (ex_mem),
		.dm_cs    (dm_cs),
		.dm_we    (dm_we),
		.dm_addr  (dm_addr),
		.dm_wdata (dm_wdata),
		.dm_rdata (dm_rdata),
		.byp      (byp.src)
	);

endmodule

/* rv_core_asserts.sv */
// Protocol checks on the core's memory ports; attached to every rv_core instance by bind
`timescale 1ns/1ps

module rv_core_asserts import rv_pkg::*; (
	input logic            clk,
	input logic            rst,
	input logic            dm_ready,
	input logic            dm_cs,
	input logic            dm_we,
	input logic [xlen-1:0] dm_addr,
	input logic [xlen-1:0] dm_wdata,
	input logic [xlen-1:0] im_addr
);

	// A write is always a selected access
	we_implies_cs: assert property (@(posedge clk) disable iff (rst) dm_we |-> dm_cs)
		else $error("dm_we high while dm_cs is low");

	im_word_aligned: assert property (@(posedge clk) disable iff (rst) im_addr[1:0] == 2'b00)
		else $error("im_addr is not word aligned");

	// Frozen pipe keeps both memory ports steady
	ports_hold: assert property (@(posedge clk) disable iff (rst)
		!dm_ready |=> $stable({dm_cs, dm_we, dm_addr, dm_wdata, im_addr}))
		else $error("memory port outputs changed while dm_ready was low");

endmodule

bind rv_core rv_core_asserts u_rv_core_asserts (
	.clk      (clk),
	.rst      (rst),
	.dm_ready (dm_ready),
	.dm_cs    (dm_cs),
	.dm_we    (dm_we),
	.dm_addr  (dm_addr),
	.dm_wdata (dm_wdata),
	.im_addr  (im_addr)
);

/* rv_pkg.sv */
// Shared widths, opcodes, ALU operations and pipeline payload types; imported by every core file
package rv_pkg;

	localparam int xlen       = 32;
	localparam int reg_addr_w = 5;
	localparam logic [xlen-1:0] reset_pc = '0;

	//////////////////////////////////////////////////////////////////////
	// RV32I opcodes and function codes
	//////////////////////////////////////////////////////////////////////
	localparam logic [6:0] OP     = 7'b0110011;
	localparam logic [6:0] OP_IMM = 7'b0010011;
	localparam logic [6:0] LOAD   = 7'b0000011;
	localparam logic [6:0] STORE  = 7'b0100011;
	localparam logic [6:0] BRANCH = 7'b1100011;
	localparam logic [6:0] JAL    = 7'b1101111;

	localparam logic [2:0] F3_ADD  = 3'b000;
	localparam logic [2:0] F3_SLT  = 3'b010;
	localparam logic [2:0] F3_XOR  = 3'b100;
	localparam logic [2:0] F3_OR   = 3'b110;
	localparam logic [2:0] F3_AND  = 3'b111;
	localparam logic [2:0] F3_BEQ  = 3'b000;
	localparam logic [2:0] F3_BNE  = 3'b001;
	localparam logic [2:0] F3_WORD = 3'b010;
	localparam logic [6:0] F7_SUB  = 7'b0100000;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_slt
	} alu_op_e;

	//////////////////////////////////////////////////////////////////////
	// Pipeline payloads
	//////////////////////////////////////////////////////////////////////
	typedef struct packed {
		logic    reg_write;
		logic    mem_read;
		logic    mem_write;
		logic    branch;
		logic    branch_ne;
		logic    jump;
		logic    alu_src_imm;
		alu_op_e alu_op;
	} ctrl_t;

	typedef struct packed {
		logic [xlen-1:0] pc;
		logic [xlen-1:0] instr;
	} if_id_t;

	typedef struct packed {
		ctrl_t                 ctrl;
		logic [xlen-1:0]       pc;
		logic [reg_addr_w-1:0] rs1;
		logic [reg_addr_w-1:0] rs2;
		logic [xlen-1:0]       rs1_val;
		logic [xlen-1:0]       rs2_val;
		logic [xlen-1:0]       imm;
		logic [reg_addr_w-1:0] rd;
	} id_ex_t;

	typedef struct packed {
		logic                  reg_write;
		logic                  mem_read;
		logic                  mem_write;
		logic [xlen-1:0]       result;
		logic [xlen-1:0]       store_data;
		logic [reg_addr_w-1:0] rd;
	} ex_mem_t;

	typedef struct packed {
		logic                  reg_write;
		logic [reg_addr_w-1:0] rd;
		logic [xlen-1:0]       wb_data;
	} mem_wb_t;

endpackage

/* stage_reg.sv */
// Generic pipeline register with hold and bubble insertion; instantiated once per stage boundary
`timescale 1ns/1ps

module stage_reg #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     rst,
	input  logic     hold,
	input  logic     flush,
	input  payload_t d,
	output payload_t q
);

	// Hold beats flush so a frozen pipe never drops an instruction
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			q <= '0;
		end else if (!hold) begin
			if (flush) begin
				// All-zero payload is a bubble
				q <= '0;
			end else begin
				q <= d;
			end
		end
	end

endmodule

/* tb_clk_gen.sv */
// Clock and reset source for the core testbench; a restart pulse applies reset again
`timescale 1ns/1ps

module tb_clk_gen #(
	parameter int period_ns    = 4,
	parameter int reset_cycles = 16
) (
	input  logic restart,
	output logic clk,
	output logic rst
);

	int unsigned rst_cnt = reset_cycles;

	initial begin
		clk = 1'b0;
		forever #(period_ns / 2) clk = ~clk;
	end

	// Reset stays high for reset_cycles rising edges
	always @(posedge clk) begin
		if (restart) begin
			rst_cnt <= reset_cycles;
		end else if (rst_cnt != 0) begin
			rst_cnt <= rst_cnt - 1;
		end
	end

	assign rst = (rst_cnt != 0);

endmodule

/* tb_rv_core.sv */
// Simulation top that runs each program twice and checks the core's stores against a model
`timescale 1ns/1ps

module tb_rv_core import rv_pkg::*; ();

	logic            clk;
	logic            rst;
	logic            restart;
	logic [xlen-1:0] im_addr;
	logic [xlen-1:0] im_data;
	logic            dm_cs;
	logic            dm_we;
	logic [xlen-1:0] dm_addr;
	logic [xlen-1:0] dm_wdata;
	logic [xlen-1:0] dm_rdata;
	logic            dm_ready;

	logic [31:0] imem [256];
	logic [31:0] dmem [256];
	logic [31:0] exp_addr [$];
	logic [31:0] exp_data [$];
	logic [31:0] end_pc;
	int          prog_len;
	int          store_idx = 0;
	int unsigned busy_pct = 0;
	int unsigned cycle_cnt = 0;
	int unsigned watchdog_limit = 1000;

	tb_clk_gen #(.period_ns(4), .reset_cycles(16)) u_clk_gen (
		.restart (restart),
		.clk     (clk),
		.rst     (rst)
	);

	rv_core u_rv_core (
		.clk      (clk),
		.rst      (rst),
		.im_addr  (im_addr),
		.im_data  (im_data),
		.dm_cs    (dm_cs),
		.dm_we    (dm_we),
		.dm_addr  (dm_addr),
		.dm_wdata (dm_wdata),
		.dm_rdata (dm_rdata),
		.dm_ready (dm_ready)
	);

	task automatic fail_now();
		$display("Simulation finished: FAIL");
		$fatal(1, "Stopped at first error");
	endtask

	//////////////////////////////////////////////////////////////////////
	// Instruction encoders and program builder
	//////////////////////////////////////////////////////////////////////
	function automatic logic [31:0] r_type(logic [2:0] f3, logic [6:0] f7, int rd, int rs1,
		int rs2);
		return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], OP};
	endfunction

	function automatic logic [31:0] i_type(logic [6:0] op, int rd, int rs1, int imm);
		return {imm[11:0], rs1[4:0], (op == LOAD) ? F3_WORD : F3_ADD, rd[4:0], op};
	endfunction

	function automatic logic [31:0] s_type(int rs2, int rs1, int off);
		return {off[11:5], rs2[4:0], rs1[4:0], F3_WORD, off[4:0], STORE};
	endfunction

	function automatic logic [31:0] b_type(logic [2:0] f3, int rs1, int rs2, int off);
		return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], BRANCH};
	endfunction

	function automatic logic [31:0] j_type(int rd, int off);
		return {off[20], off[10:1], off[11], off[19:12], rd[4:0], JAL};
	endfunction

	// Power-on data memory contents
	function automatic logic [31:0] fill_word(int idx);
		return (idx * 32'h9E3779B1) ^ 32'h00C0FFEE;
	endfunction

	task automatic emit(input logic [31:0] word);
		imem[prog_len] = word;
		prog_len++;
	endtask

	task automatic load_program(input int prog_id);
		prog_len = 0;
		for (int i = 0; i < 256; i++) begin
			imem[i] = '0;
		end
		case (prog_id)
			0: begin
				emit(i_type(OP_IMM, 1, 0, 'h123));
				emit(i_type(OP_IMM, 2, 0, -69));
				emit(r_type(F3_ADD, 7'h00, 3, 1, 2));
				emit(s_type(3, 0, 'h100));
				emit(r_type(F3_ADD, F7_SUB, 4, 1, 2));
				emit(s_type(4, 0, 'h104));
				emit(r_type(F3_AND, 7'h00, 5, 1, 2));
				emit(s_type(5, 0, 'h108));
				emit(r_type(F3_OR, 7'h00, 6, 1, 2));
				emit(s_type(6, 0, 'h10C));
				emit(r_type(F3_XOR, 7'h00, 7, 1, 2));
				emit(s_type(7, 0, 'h110));
				emit(r_type(F3_SLT, 7'h00, 8, 2, 1));
				emit(s_type(8, 0, 'h114));
				emit(r_type(F3_SLT, 7'h00, 9, 1, 2));
				emit(s_type(9, 0, 'h118));
				emit(s_type(2, 0, 'h11C));
				emit(s_type(1, 0, 'h120));
			end
			1: begin
				// Dependent chains and load-use pairs
				emit(i_type(OP_IMM, 1, 0, 5));
				emit(i_type(OP_IMM, 1, 1, 7));
				emit(r_type(F3_ADD, 7'h00, 2, 1, 1));
				emit(r_type(F3_ADD, 7'h00, 3, 2, 1));
				emit(s_type(3, 0, 'h200));
				emit(s_type(2, 0, 'h204));
				emit(i_type(LOAD, 4, 0, 'h200));
				emit(r_type(F3_ADD, 7'h00, 5, 4, 1));
				emit(s_type(5, 0, 'h208));
				emit(i_type(LOAD, 6, 0, 'h40));
				emit(s_type(6, 0, 'h20C));
				emit(i_type(LOAD, 7, 0, 'h44));
				emit(i_type(OP_IMM, 8, 7, 1));
				emit(s_type(8, 0, 'h210));
				emit(i_type(OP_IMM, 9, 0, 'h300));
				emit(s_type(5, 9, 0));
			end
			default: begin
				// Stores sit in every branch shadow
				emit(i_type(OP_IMM, 1, 0, 3));
				emit(i_type(OP_IMM, 2, 0, 3));
				emit(b_type(F3_BEQ, 1, 2, 12));
				emit(s_type(1, 0, 'h300));
				emit(s_type(2, 0, 'h304));
				emit(s_type(1, 0, 'h308));
				emit(b_type(F3_BNE, 1, 2, 12));
				emit(s_type(1, 0, 'h30C));
				emit(i_type(OP_IMM, 3, 0, 9));
				emit(b_type(F3_BNE, 1, 3, 12));
				emit(s_type(3, 0, 'h310));
				emit(s_type(3, 0, 'h314));
				emit(b_type(F3_BEQ, 1, 3, 8));
				emit(s_type(3, 0, 'h318));
				emit(j_type(4, 12));
				emit(s_type(4, 0, 'h31C));
				emit(s_type(4, 0, 'h320));
				emit(s_type(4, 0, 'h324));
			end
		endcase
		// Closing loop on itself
		emit(j_type(0, 0));
		end_pc = (prog_len - 1) * 4;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Reference model stepping one instruction at a time
	//////////////////////////////////////////////////////////////////////
	function automatic int unsigned model_run();
		logic [31:0] x [32];
		logic [31:0] mem [256];
		logic [31:0] pc;
		logic [31:0] pc_next;
		logic [31:0] ins;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] r;
		logic [31:0] ea;
		logic [31:0] imm_i;
		logic [31:0] imm_s;
		logic [31:0] imm_b;
		logic [31:0] imm_j;
		logic        wr;
		logic        done;
		int unsigned steps;
		for (int i = 0; i < 32; i++) begin
			x[i] = '0;
		end
		for (int i = 0; i < 256; i++) begin
			mem[i] = fill_word(i);
		end
		exp_addr.delete();
		exp_data.delete();
		pc    = reset_pc;
		done  = 1'b0;
		steps = 0;
		while (!done && steps < 1000) begin
			ins     = imem[pc[9:2]];
			a       = x[ins[19:15]];
			b       = x[ins[24:20]];
			imm_i   = {{20{ins[31]}}, ins[31:20]};
			imm_s   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
			imm_b   = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
			imm_j   = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
			pc_next = pc + 4;
			r       = '0;
			wr      = 1'b0;
			case (ins[6:0])
				OP: begin
					wr = 1'b1;
					case (ins[14:12])
						F3_ADD:  r = ins[30] ? a - b : a + b;
						F3_SLT:  r = {31'b0, $signed(a) < $signed(b)};
						F3_XOR:  r = a ^ b;
						F3_OR:   r = a | b;
						F3_AND:  r = a & b;
						default: wr = 1'b0;
					endcase
				end
				OP_IMM: begin
					wr = 1'b1;
					r  = a + imm_i;
				end
				LOAD: begin
					wr = 1'b1;
					ea = a + imm_i;
					r  = mem[ea[9:2]];
				end
				STORE: begin
					ea = a + imm_s;
					mem[ea[9:2]] = b;
					exp_addr.push_back(ea);
					exp_data.push_back(b);
				end
				BRANCH: begin
					if ((ins[14:12] == F3_BNE) ? (a != b) : (a == b)) begin
						pc_next = pc + imm_b;
					end
				end
				JAL: begin
					wr      = 1'b1;
					r       = pc + 4;
					pc_next = pc + imm_j;
					done    = (imm_j == 0);
				end
				default: begin
				end
			endcase
			if (wr && ins[11:7] != 5'd0) begin
				x[ins[11:7]] = r;
			end
			pc = pc_next;
			steps++;
		end
		return steps;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Memory models, ready generator, store checker and watchdog
	//////////////////////////////////////////////////////////////////////
	assign im_data  = imem[im_addr[9:2]];
	assign dm_rdata = dmem[dm_addr[9:2]];

	initial begin
		for (int i = 0; i < 256; i++) begin
			dmem[i] <= fill_word(i);
		end
		forever begin
			@(posedge clk);
			if (rst) begin
				for (int i = 0; i < 256; i++) begin
					dmem[i] <= fill_word(i);
				end
			end else if (dm_cs && dm_we && dm_ready) begin
				dmem[dm_addr[9:2]] <= dm_wdata;
			end
		end
	end

	initial begin
		void'($urandom(87));
		dm_ready = 1'b1;
		forever begin
			@(negedge clk);
			dm_ready = ($urandom_range(99) >= busy_pct);
		end
	end

	// One completed write per ready edge with dm_cs and dm_we
	always @(posedge clk) begin
		if (rst) begin
			store_idx = 0;
		end else if (dm_cs && dm_we && dm_ready) begin
			assert (store_idx < exp_addr.size()) else begin
				$display("Extra store to address %h, the model expects only %0d stores",
					dm_addr, exp_addr.size());
				fail_now();
			end
			assert (dm_addr == exp_addr[store_idx]) else begin
				$display("FAILED dm_addr: got %h, expected %h", dm_addr, exp_addr[store_idx]);
				fail_now();
			end
			assert (dm_wdata == exp_data[store_idx]) else begin
				$display("FAILED dm_wdata: got %h, expected %h", dm_wdata, exp_data[store_idx]);
				fail_now();
			end
			store_idx++;
		end
	end

	always @(posedge clk) begin
		if (rst) begin
			cycle_cnt = 0;
		end else begin
			cycle_cnt++;
			if (cycle_cnt > watchdog_limit) begin
				$display("Timeout, program not finished within %0d cycles", watchdog_limit);
				fail_now();
			end
		end
	end

	task automatic check_reset_state();
		assert (dm_cs === 1'b0) else begin
			$display("FAILED dm_cs: got %h, expected %h", dm_cs, 1'b0);
			fail_now();
		end
		assert (im_addr === reset_pc) else begin
			$display("FAILED im_addr: got %h, expected %h", im_addr, reset_pc);
			fail_now();
		end
	endtask

	task automatic run_program(input int prog_id, input int unsigned busy);
		int unsigned n_exec;
		int unsigned ready_seen;
		busy_pct = busy;
		@(negedge clk);
		restart = 1'b1;
		@(negedge clk);
		restart = 1'b0;
		load_program(prog_id);
		n_exec = model_run();
		watchdog_limit = 8 * n_exec + 200;
		while (rst) begin
			check_reset_state();
			@(negedge clk);
		end
		// First cycle out of reset
		check_reset_state();
		while (im_addr != end_pc) begin
			@(negedge clk);
		end
		// Older instructions drain out of the pipe
		ready_seen = 0;
		while (ready_seen < 8) begin
			@(posedge clk);
			if (dm_ready) begin
				ready_seen++;
			end
		end
		@(negedge clk);
		assert (store_idx == exp_addr.size()) else begin
			$display("Program %0d ended with %0d of %0d expected stores missing", prog_id,
				exp_addr.size() - store_idx, exp_addr.size());
			fail_now();
		end
	endtask

	initial begin
		restart = 1'b0;
		for (int i = 0; i < 256; i++) begin
			imem[i] = '0;
		end
		// Second round with dm_ready low on about 30 percent of cycles
		for (int round = 0; round < 2; round++) begin
			for (int prog = 0; prog < 3; prog++) begin
				run_program(prog, (round == 0) ? 0 : 30);
			end
		end
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule
